/* Makefile */
VERILATOR ?= verilator
TOP ?= decodeExecuteTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the pass line shows up in the simulator output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/decodeExecuteTb.sv */
`default_nettype none
`include "rv_settings.svh"

module decodeExecuteTb;

    localparam logic [31:0] SEED = 32'h22e3_9a11;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int ALU_COUNT = 40;
    localparam int UPPER_COUNT = 12;
    localparam int BRANCH_COUNT = 48;
    localparam int BYPASS_COUNT = 8;
    localparam int AFTER_COUNT = 12;
    localparam int TOTAL_INSTR = 2 * ALU_COUNT + 3 * UPPER_COUNT + BRANCH_COUNT
                                 + BYPASS_COUNT + AFTER_COUNT + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_INSTR * 20;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    rvPipePkg::issue_t     issue;
    logic                  inValid;
    logic                  inReady;
    rvPipePkg::exeResult_t result;
    logic                  exValid;
    logic                  exReady;
    logic                  wbValid;
    logic [`RV_REGW-1:0]   wbAddr;
    logic [`RV_XLEN-1:0]   wbData;

    logic [`RV_XLEN-1:0]   model [`RV_NREGS];
    logic [31:0]           rngState = SEED;
    logic                  holdReady = 1'b0;
    rvPipePkg::exeResult_t expQ [$];
    string                 nameQ [$];
    logic                  flowQ [$];
    int                    mismatches = 0;
    int                    unexpected = 0;
    int                    otherErrors = 0;
    int                    flushedCount = 0;

    decodeExecuteTop decodeExecuteTop_i (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .issue   (issue),
        .inValid (inValid),
        .inReady (inReady),
        .result  (result),
        .exValid (exValid),
        .exReady (exReady),
        .wbValid (wbValid),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

    bind decodeExecuteTop decodeExecute_chk decodeExecute_chk_i (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .inReady (inReady),
        .exValid (exValid),
        .exReady (exReady),
        .result  (result)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Legal OP or OP-IMM encoding with random fields.
    function automatic logic [31:0] aluInstr(input logic useImm);
        logic [31:0] r;
        logic        alt;
        r = randWord();
        alt = r[30] && (r[14:12] == 3'b101 || (r[14:12] == 3'b000 && !useImm));
        if (!useImm || r[13:12] == 2'b01) begin
            r[31:25] = {1'b0, alt, 5'b0};  // Shifts and register ops have a fixed funct7.
        end
        r[6:0] = useImm ? 7'b0010011 : 7'b0110011;
        return r;
    endfunction

    function automatic logic [31:0] upperInstr(input logic [6:0] opcode);
        logic [31:0] r;
        r = randWord();
        r[6:0] = opcode;
        return r;
    endfunction

    function automatic logic [31:0] branchInstr();
        logic [31:0] r;
        r = randWord();
        if (r[14:13] == 2'b01) begin
            r[14] = 1'b1;  // Funct3 2 and 3 are not branches.
        end
        if (r[0]) begin
            r[24:20] = r[19:15];
        end
        r[6:0] = 7'b1100011;
        return r;
    endfunction

    function automatic rvPipePkg::exeResult_t expectedResult(
        input rvPipePkg::issue_t iss,
        input logic [`RV_XLEN-1:0] regs [`RV_NREGS]
    );
        logic [31:0]           ins;
        logic [31:0]           a;
        logic [31:0]           b;
        rvPipePkg::exeResult_t r;
        ins = iss.instr;
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        r = '0;
        r.pc = iss.pc;
        r.rd = ins[11:7];
        r.regWrite = 1'b1;
        case (ins[6:0])
            7'b0110011, 7'b0010011: begin
                if (!ins[5]) begin
                    b = {{20{ins[31]}}, ins[31:20]};  // OP-IMM uses the I immediate.
                end
                case (ins[14:12])
                    3'b000: r.value = (ins[5] && ins[30]) ? a - b : a + b;
                    3'b001: r.value = a << b[4:0];
                    3'b010: r.value = {31'b0, $signed(a) < $signed(b)};
                    3'b011: r.value = {31'b0, a < b};
                    3'b100: r.value = a ^ b;
                    3'b101: begin
                        if (ins[30]) begin
                            r.value = $unsigned($signed(a) >>> b[4:0]);
                        end else begin
                            r.value = a >> b[4:0];
                        end
                    end
                    3'b110: r.value = a | b;
                    default: r.value = a & b;
                endcase
            end
            7'b0110111: r.value = {ins[31:12], 12'b0};
            7'b0010111: r.value = iss.pc + {ins[31:12], 12'b0};
            7'b1101111: begin
                r.value = iss.pc + 32'd4;
                r.branchTaken = 1'b1;
                r.target = iss.pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                     ins[30:21], 1'b0};
            end
            default: begin
                r.regWrite = 1'b0;
                r.target = iss.pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                     ins[11:8], 1'b0};
                case (ins[14:12])
                    3'b000: r.branchTaken = a == b;
                    3'b001: r.branchTaken = a != b;
                    3'b100: r.branchTaken = $signed(a) < $signed(b);
                    3'b101: r.branchTaken = $signed(a) >= $signed(b);
                    3'b110: r.branchTaken = a < b;
                    default: r.branchTaken = a >= b;
                endcase
            end
        endcase
        return r;
    endfunction

    task automatic mismatch(input string test, input string field, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        $display("Fail %s %s: expected %h, actual %h", test, field, expVal, actVal);
        mismatches++;
    endtask

    task automatic printCounts();
        $display("Errors: %0d mismatches, %0d unexpected results, %0d other",
                 mismatches, unexpected, otherErrors);
    endtask

    // Called just after a rising edge; returns at the same point of a later cycle.
    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        wbValid = 1'b1;
        wbAddr = addr;
        wbData = data;
        if (addr != 5'd0) begin
            model[addr] = data;
        end
        @(posedge clk);
        #1;
        wbValid = 1'b0;
    endtask

    task automatic sendInstr(input string name, input logic [31:0] instr, input logic flow,
                             input logic wb, input logic [4:0] wa, input logic [31:0] wd);
        rvPipePkg::issue_t     iss;
        rvPipePkg::exeResult_t expVal;
        logic [31:0]           w;
        w = randWord();
        iss.pc = {w[31:2], 2'b00};
        iss.instr = instr;
        issue = iss;
        inValid = 1'b1;
        wbValid = wb;
        wbAddr = wa;
        wbData = wd;
        @(negedge clk);
        while (!inReady) begin
            @(negedge clk);
        end
        if (wb && wa != 5'd0) begin
            model[wa] = wd;  // The bypass makes this write visible to the read.
        end
        expVal = expectedResult(iss, model);
        @(posedge clk);
        #1;
        expQ.push_back(expVal);
        nameQ.push_back(name);
        flowQ.push_back(flow);
        inValid = 1'b0;
        wbValid = 1'b0;
    endtask

    task automatic drain();
        while (expQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        logic [31:0] readyRng;
        readyRng = SEED ^ 32'h5bd1_e995;  // Separate stream from the instruction stimulus.
        exReady = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            readyRng = xorshift(readyRng);
            exReady = !holdReady && (readyRng[1:0] != 2'b00);
        end
    end

    initial begin
        rvPipePkg::exeResult_t expVal;
        string                 name;
        logic                  flow;
        forever begin
            @(negedge clk);
            if (exValid && exReady) begin
                if (expQ.size() == 0) begin
                    $display("Error: a result came out with no instruction outstanding");
                    unexpected++;
                end else begin
                    expVal = expQ.pop_front();
                    name = nameQ.pop_front();
                    flow = flowQ.pop_front();
                    if (result.pc !== expVal.pc) begin
                        mismatch(name, "pc", expVal.pc, result.pc);
                    end
                    if (result.regWrite !== expVal.regWrite) begin
                        mismatch(name, "regWrite", {31'b0, expVal.regWrite},
                                 {31'b0, result.regWrite});
                    end
                    if (expVal.regWrite && result.rd !== expVal.rd) begin
                        mismatch(name, "rd", {27'b0, expVal.rd}, {27'b0, result.rd});
                    end
                    if (expVal.regWrite && result.value !== expVal.value) begin
                        mismatch(name, "value", expVal.value, result.value);
                    end
                    if (result.branchTaken !== expVal.branchTaken) begin
                        mismatch(name, "branchTaken", {31'b0, expVal.branchTaken},
                                 {31'b0, result.branchTaken});
                    end
                    if (flow && result.target !== expVal.target) begin
                        mismatch(name, "target", expVal.target, result.target);
                    end
                end
            end else if (exValid && flush && expQ.size() != 0) begin
                void'(expQ.pop_front());  // Discarded by the flush.
                void'(nameQ.pop_front());
                void'(flowQ.pop_front());
                flushedCount++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired before every result was checked");
        otherErrors++;
        printCounts();
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] w;
        logic [4:0]  addr;
        reset = 1'b1;
        flush = 1'b0;
        issue = '0;
        inValid = 1'b0;
        wbValid = 1'b0;
        wbAddr = '0;
        wbData = '0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 1; i < `RV_NREGS; i++) begin
            writeReg(5'(i), randWord());
        end
        for (int i = 0; i < ALU_COUNT; i++) begin
            w = randWord();
            if (w[2:0] == 3'b000) begin
                writeReg(w[12:8], randWord());
            end
            sendInstr("opReg", aluInstr(1'b0), 1'b0, 1'b0, 5'd0, 32'd0);
            sendInstr("opImm", aluInstr(1'b1), 1'b0, 1'b0, 5'd0, 32'd0);
        end
        for (int i = 0; i < UPPER_COUNT; i++) begin
            sendInstr("lui", upperInstr(7'b0110111), 1'b0, 1'b0, 5'd0, 32'd0);
            sendInstr("auipc", upperInstr(7'b0010111), 1'b0, 1'b0, 5'd0, 32'd0);
            sendInstr("jal", upperInstr(7'b1101111), 1'b1, 1'b0, 5'd0, 32'd0);
        end
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            sendInstr("branch", branchInstr(), 1'b1, 1'b0, 5'd0, 32'd0);
        end

        writeReg(5'd0, 32'hffff_ffff);
        sendInstr("x0", {7'b0, 5'd0, 5'd0, 3'b110, 5'd7, 7'b0110011}, 1'b0,
                  1'b1, 5'd0, randWord());
        for (int i = 0; i < BYPASS_COUNT; i++) begin
            w = randWord();
            addr = (w[4:0] == 5'd0) ? 5'd1 : w[4:0];
            sendInstr("bypass", {7'b0, w[9:5], addr, 3'b000, w[14:10], 7'b0110011}, 1'b0,
                      1'b1, addr, randWord());
        end

        drain();
        @(negedge clk);
        holdReady = 1'b1;
        @(posedge clk);
        #1;
        sendInstr("flush", aluInstr(1'b1), 1'b0, 1'b0, 5'd0, 32'd0);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        holdReady = 1'b0;
        @(posedge clk);
        #1;
        for (int i = 0; i < AFTER_COUNT; i++) begin
            sendInstr("afterFlush", aluInstr(1'b0), 1'b0, 1'b0, 5'd0, 32'd0);
        end

        drain();
        repeat (4) @(posedge clk);
        #1;
        if (flushedCount != 1) begin
            $display("Error: the flush discarded %0d instructions instead of one", flushedCount);
            otherErrors++;
        end
        printCounts();
        if (mismatches + unexpected + otherErrors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/decodeExecute_chk.sv */
`default_nettype none

module decodeExecute_chk (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input logic                  inReady,
    input logic                  exValid,
    input logic                  exReady,
    input rvPipePkg::exeResult_t result
);

    resetClearsValid: assert property (@(posedge clk) reset |-> !exValid)
        else $error("exValid is high while reset is asserted");

    // A stalled result must hold until the consumer takes it.
    stallHoldsResult: assert property (@(posedge clk) disable iff (reset)
        exValid && !exReady && !flush |=> exValid && $stable(result))
        else $error("result or exValid changed while stalled");

    flushEmptiesStage: assert property (@(posedge clk) disable iff (reset) flush |=> !exValid)
        else $error("exValid is high in the cycle after a flush");

    flushBlocksInput: assert property (@(posedge clk) flush |-> !inReady)
        else $error("inReady is high while flush is asserted");

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/rvIsaPkg.sv
hw/rvPipePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/idExeReg.sv
hw/aluExecute.sv
hw/decodeExecuteTop.sv
bench/decodeExecute_chk.sv
bench/decodeExecuteTb.sv

/* hw/aluExecute.sv */
`default_nettype none
`include "rv_settings.svh"

module aluExecute (
    input  rvPipePkg::idExe_t     stage,
    output rvPipePkg::exeResult_t result
);

    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] aluOut;
    logic                taken;

    assign opA = stage.pcSrcA ? stage.pc : stage.rs1Data;
    assign opB = stage.aluSrcImm ? stage.imm : stage.rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (stage.aluOp)
            rvIsaPkg::ADD:   aluOut = opA + opB;
            rvIsaPkg::SUB:   aluOut = opA - opB;
            rvIsaPkg::AND:   aluOut = opA & opB;
            rvIsaPkg::OR:    aluOut = opA | opB;
            rvIsaPkg::XOR:   aluOut = opA ^ opB;
            rvIsaPkg::SLL:   aluOut = opA << shamt;
            rvIsaPkg::SRL:   aluOut = opA >> shamt;
            rvIsaPkg::SRA:   aluOut = $unsigned($signed(opA) >>> shamt);
            rvIsaPkg::SLT:   aluOut = {{(`RV_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            rvIsaPkg::SLTU:  aluOut = {{(`RV_XLEN-1){1'b0}}, opA < opB};
            rvIsaPkg::PASSB: aluOut = opB;
            default:         aluOut = '0;
        endcase
    end

    // Branches always compare the two register operands.
    always_comb begin
        case (stage.brCond)
            rvIsaPkg::EQ:   taken = stage.rs1Data == stage.rs2Data;
            rvIsaPkg::NE:   taken = stage.rs1Data != stage.rs2Data;
            rvIsaPkg::LT:   taken = $signed(stage.rs1Data) < $signed(stage.rs2Data);
            rvIsaPkg::GE:   taken = $signed(stage.rs1Data) >= $signed(stage.rs2Data);
            rvIsaPkg::LTU:  taken = stage.rs1Data < stage.rs2Data;
            rvIsaPkg::GEU:  taken = stage.rs1Data >= stage.rs2Data;
            rvIsaPkg::JUMP: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        result.pc = stage.pc;
        result.rd = stage.rd;
        result.regWrite = stage.regWrite;
        result.branchTaken = taken;
        result.target = stage.pc + stage.imm;
        if (stage.brCond == rvIsaPkg::JUMP) begin
            result.value = stage.pc + `RV_XLEN'd4;  // Link address.
        end else begin
            result.value = aluOut;
        end
    end

endmodule

`default_nettype wire

/* hw/decodeExecuteTop.sv */
`default_nettype none
`include "rv_settings.svh"

module decodeExecuteTop (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  rvPipePkg::issue_t     issue,
    input  logic                  inValid,
    output logic                  inReady,
    output rvPipePkg::exeResult_t result,
    output logic                  exValid,
    input  logic                  exReady,
    input  logic                  wbValid,
    input  logic [`RV_REGW-1:0]   wbAddr,
    input  logic [`RV_XLEN-1:0]   wbData
);

    logic [`RV_REGW-1:0] rs1;
    logic [`RV_REGW-1:0] rs2;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic                legal;
    rvPipePkg::idExe_t   decCtrl;
    rvPipePkg::idExe_t   idExeIn;
    rvPipePkg::idExe_t   stage;

    instrDecoder instrDecoder_i (
        .instr (issue.instr),
        .rs1   (rs1),
        .rs2   (rs2),
        .ctrl  (decCtrl),
        .legal (legal)
    );

    regFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbValid (wbValid),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

    always_comb begin
        idExeIn = decCtrl;
        idExeIn.pc = issue.pc;
        idExeIn.rs1Data = rs1Data;
        idExeIn.rs2Data = rs2Data;
        idExeIn.regWrite = decCtrl.regWrite && legal;  // Illegal encodings become bubbles.
    end

    idExeReg idExeReg_i (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .inValid  (inValid),
        .inReady  (inReady),
        .dIn      (idExeIn),
        .valid    (exValid),
        .dOut     (stage),
        .outReady (exReady)
    );

    aluExecute aluExecute_i (
        .stage  (stage),
        .result (result)
    );

endmodule

`default_nettype wire

/* hw/idExeReg.sv */
`default_nettype none

module idExeReg (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              inValid,
    output logic              inReady,
    input  rvPipePkg::idExe_t dIn,
    output logic              valid,
    output rvPipePkg::idExe_t dOut,
    input  logic              outReady
);

    logic accept;

    // Free when empty or when the held entry leaves this cycle.
    assign inReady = !flush && (!valid || outReady);
    assign accept = inValid && inReady;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
            dOut <= '0;
        end else if (flush) begin
            valid <= 1'b0;  // Held instruction is discarded.
            dOut <= '0;
        end else if (accept) begin
            valid <= 1'b1;
            dOut <= dIn;
        end else if (outReady) begin
            valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/instrDecoder.sv */
`default_nettype none
`include "rv_settings.svh"

module instrDecoder (
    input  logic [31:0]          instr,
    output logic [`RV_REGW-1:0]  rs1,
    output logic [`RV_REGW-1:0]  rs2,
    output rvPipePkg::idExe_t    ctrl,
    output logic                 legal
);

    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immU;
    logic [`RV_XLEN-1:0] immB;
    logic [`RV_XLEN-1:0] immJ;

    function automatic rvIsaPkg::aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvIsaPkg::SUB : rvIsaPkg::ADD;
            3'b001:  return rvIsaPkg::SLL;
            3'b010:  return rvIsaPkg::SLT;
            3'b011:  return rvIsaPkg::SLTU;
            3'b100:  return rvIsaPkg::XOR;
            3'b101:  return alt ? rvIsaPkg::SRA : rvIsaPkg::SRL;
            3'b110:  return rvIsaPkg::OR;
            default: return rvIsaPkg::AND;
        endcase
    endfunction

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immU = {instr[31:12], 12'b0};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        ctrl.rd = instr[11:7];
        ctrl.aluOp = rvIsaPkg::ADD;
        ctrl.brCond = rvIsaPkg::NONE;
        legal = 1'b1;
        case (rvIsaPkg::opcode_t'(instr[6:0]))
            rvIsaPkg::OP: begin
                ctrl.aluOp = aluFromFunct(funct3, funct7[5]);
                ctrl.regWrite = 1'b1;
                // Only ADD/SUB and SRL/SRA have an alternate encoding.
                legal = (funct7 == 7'b0) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rvIsaPkg::OP_IMM: begin
                ctrl.aluOp = aluFromFunct(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.imm = immI;
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0) || (funct7 == 7'b0100000);
                end
            end
            rvIsaPkg::LUI: begin
                ctrl.aluOp = rvIsaPkg::PASSB;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.imm = immU;
            end
            rvIsaPkg::AUIPC: begin
                ctrl.pcSrcA = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.imm = immU;
            end
            rvIsaPkg::BRANCH: begin
                ctrl.imm = immB;
                case (funct3)
                    3'b000:  ctrl.brCond = rvIsaPkg::EQ;
                    3'b001:  ctrl.brCond = rvIsaPkg::NE;
                    3'b100:  ctrl.brCond = rvIsaPkg::LT;
                    3'b101:  ctrl.brCond = rvIsaPkg::GE;
                    3'b110:  ctrl.brCond = rvIsaPkg::LTU;
                    3'b111:  ctrl.brCond = rvIsaPkg::GEU;
                    default: legal = 1'b0;
                endcase
            end
            rvIsaPkg::JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.brCond = rvIsaPkg::JUMP;
                ctrl.imm = immJ;
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`default_nettype none
`include "rv_settings.svh"

module regFile (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_REGW-1:0] rs1,
    input  logic [`RV_REGW-1:0] rs2,
    output logic [`RV_XLEN-1:0] rs1Data,
    output logic [`RV_XLEN-1:0] rs2Data,
    input  logic                wbValid,
    input  logic [`RV_REGW-1:0] wbAddr,
    input  logic [`RV_XLEN-1:0] wbData
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wrEn;

    assign wrEn = wbValid && (wbAddr != '0);

    // A write in flight wins over the stored copy.
    function automatic logic [`RV_XLEN-1:0] readPort(input logic [`RV_REGW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn && wbAddr == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wbAddr] <= wbData;
        end
    end

endmodule

`default_nettype wire

/* hw/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASSB  // Second operand straight through, for LUI.
    } aluOp_t;

    typedef enum logic [2:0] {
        NONE,
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU,
        JUMP
    } brCond_t;

endpackage

`default_nettype wire

/* hw/rvPipePkg.sv */
`default_nettype none
`include "rv_settings.svh"

package rvPipePkg;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instr;
    } issue_t;

    // Everything execute needs, captured at the ID/EX boundary.
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1Data;
        logic [`RV_XLEN-1:0] rs2Data;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_REGW-1:0] rd;
        rvIsaPkg::aluOp_t    aluOp;
        logic                aluSrcImm;  // Second operand is the immediate.
        logic                pcSrcA;     // First operand is the pc.
        logic                regWrite;
        rvIsaPkg::brCond_t   brCond;
    } idExe_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_REGW-1:0] rd;
        logic                regWrite;
        logic [`RV_XLEN-1:0] value;
        logic                branchTaken;
        logic [`RV_XLEN-1:0] target;
    } exeResult_t;

endpackage

`default_nettype wire

/* hw/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Integer register width of the RV32I core.
`define RV_XLEN 32

// Architectural register count, x0 included.
`define RV_NREGS 32

// Width of a register index in the instruction word.
`define RV_REGW 5

`endif
